// File: turfio_req_gen.f
rtl/req_gen_pkg.sv
rtl/req_sync_fifo.sv
rtl/req_cmd_ctrl.sv
rtl/dm_status_track.sv
rtl/req_gen_top.sv
sim/tb_clkgen.sv
sim/req_gen_assert.sv
sim/tb_req_gen.sv

// File: run.sh
#!/bin/sh
# build and run the turfio_req_gen testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_req_gen \
    -f turfio_req_gen.f \
    -o sim_req_gen

./obj_dir/sim_req_gen | tee sim.log

if grep -q "Testbench passed" sim.log; then
    exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

// File: sim/tb_req_gen.sv
module tb_req_gen;
    import req_gen_pkg::*;

    localparam logic [6:0] BASE_4KB = 7'd5;
    // rough cycle counts per test, limit is four times the sum
    localparam int LEN_SPACE = 10;
    localparam int LEN_CMDS = 300;
    localparam int LEN_CMPL = 150;
    localparam int LEN_OVF = 150;
    localparam int LEN_UNF = 30;
    localparam int CYCLE_LIMIT = 4 * (LEN_SPACE + LEN_CMDS + LEN_CMPL + LEN_OVF + LEN_UNF);

    logic memclk;
    logic memresetn;
    logic payload_valid;
    logic payload_last;
    ident_t payload_ident;
    logic payload_has_space;
    logic s_done_tvalid;
    logic [15:0] s_done_tdata;
    logic s_done_tready;
    dm_cmd_t m_cmd_tdata;
    logic m_cmd_tvalid;
    logic m_cmd_tready;
    logic s_stat_tvalid;
    dm_status_t s_stat_tdata;
    cmpl_t m_cmpl_tdata;
    logic m_cmpl_tvalid;
    logic m_cmpl_tready;
    fifo_err_t cmd_err;

    // model state
    logic [71:0] exp_cmd[$];
    logic [71:0] exp_cmpl[$];
    logic [12:0] done_q[$];
    logic cmd_check_en;
    logic cmpl_check_en;
    logic hold_cmd_ready;
    int checks;
    int errors;
    int tests;
    int cycles;
    int err_mark;
    logic [12:0] addr;

    tb_clkgen u_clk (.memclk_o(memclk), .memresetn_o(memresetn));

    req_gen_top #(.BASE_ADDRESS_4KB(BASE_4KB)) u_dut (
        .memclk(memclk), .memresetn(memresetn),
        .payload_valid_i(payload_valid), .payload_last_i(payload_last),
        .payload_ident_i(payload_ident), .payload_has_space_o(payload_has_space),
        .s_done_tvalid_i(s_done_tvalid), .s_done_tdata_i(s_done_tdata),
        .s_done_tready_o(s_done_tready),
        .m_cmd_tdata_o(m_cmd_tdata), .m_cmd_tvalid_o(m_cmd_tvalid),
        .m_cmd_tready_i(m_cmd_tready),
        .s_stat_tvalid_i(s_stat_tvalid), .s_stat_tdata_i(s_stat_tdata),
        .m_cmpl_tdata_o(m_cmpl_tdata), .m_cmpl_tvalid_o(m_cmpl_tvalid),
        .m_cmpl_tready_i(m_cmpl_tready), .cmd_err_o(cmd_err)
    );

    task automatic compare(input string name, input logic [71:0] exp, input logic [71:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // tag, address and btt of one expected command
    function automatic logic [71:0] cmd_model(input logic [12:0] done, input int c, input int s);
        logic [8:0] kb;
        logic [3:0] tag;
        kb = 9'(BASE_4KB * 4 + c * 4 + s * 16);
        tag = (c == 3 && s == 6) ? 4'd1 : 4'd0;
        return {13'h0, tag, done, kb, 10'h000, 23'd4096};
    endfunction

    task automatic finish_test(input string name);
        tests++;
        $display("test %s finished, %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    ////////////////////////////////////////
    // chunk marker source
    ////////////////////////////////////////

    // one event: four chunks of seven SURFs, FSM takes a marker every other cycle
    task automatic run_event(input logic [15:0] done_word);
        s_done_tvalid = 1'b1;
        s_done_tdata = done_word;
        for (int c = 0; c < 4; c++) begin
            while (!payload_has_space) @(negedge memclk);
            // start marker, then ident held through the base load
            payload_valid = 1'b1;
            payload_last = 1'b0;
            payload_ident = '{chunk: 2'(c), surf: 3'd0};
            @(negedge memclk);
            payload_valid = 1'b0;
            @(negedge memclk);
            for (int s = 0; s < 7; s++) begin
                payload_valid = 1'b1;
                payload_last = 1'b1;
                payload_ident = '{chunk: 2'(c), surf: 3'(s)};
                if (cmd_check_en) exp_cmd.push_back(cmd_model(done_word[12:0], c, s));
                @(posedge memclk);
                // done address handed over with the final command only
                compare("take", (c == 3 && s == 6) ? 72'd1 : 72'd0, {71'd0, s_done_tready});
                @(negedge memclk);
                payload_valid = 1'b0;
                payload_last = 1'b0;
                if (s != 6) @(negedge memclk);
            end
        end
        // done address was taken with the final command
        s_done_tvalid = 1'b0;
    endtask

    // 28 status bytes, last flag on the final one
    task automatic run_status(input logic [12:0] done);
        dm_status_t st;
        logic [3:0] nib;
        logic [31:0] word;
        word = '0;
        for (int k = 1; k <= 28; k++) begin
            st = dm_status_t'($urandom);
            st.last = (k == 28);
            nib = {~st.okay, st.err};
            word[3:0] = word[3:0] | nib;
            if (k < 28) word[3 + k] = |nib;
            else word[31] = |nib;
            s_stat_tvalid = 1'b1;
            s_stat_tdata = st;
            @(negedge memclk);
        end
        s_stat_tvalid = 1'b0;
        exp_cmpl.push_back({8'h0, 19'h0, done, word});
    endtask

    task automatic one_status(input logic last);
        s_stat_tvalid = 1'b1;
        s_stat_tdata = '{okay: 1'b1, err: 3'b000, rsvd: 3'b000, last: last};
        @(negedge memclk);
        s_stat_tvalid = 1'b0;
    endtask

    ////////////////////////////////////////
    // output sinks and monitors
    ////////////////////////////////////////

    always @(negedge memclk) begin
        m_cmd_tready <= hold_cmd_ready ? 1'b0 : ($urandom % 4 != 0);
        m_cmpl_tready <= ($urandom % 2 != 0);
    end

    always @(posedge memclk) begin
        if (memresetn && m_cmd_tvalid && m_cmd_tready && cmd_check_en) begin
            if (exp_cmd.size() == 0) begin
                errors++;
                $display("a command came out when none was expected");
            end else begin
                compare("cmds", exp_cmd.pop_front(),
                        {13'h0, m_cmd_tdata.tag, m_cmd_tdata.addr, m_cmd_tdata.btt});
            end
        end
    end

    always @(posedge memclk) begin
        if (memresetn && m_cmpl_tvalid && m_cmpl_tready && cmpl_check_en) begin
            if (exp_cmpl.size() == 0) begin
                errors++;
                $display("a completion came out when none was expected");
            end else begin
                compare("cmpl", exp_cmpl.pop_front(), {8'h0, m_cmpl_tdata});
            end
        end
    end

    always @(posedge memclk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, run stopped", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        payload_valid = 1'b0;
        payload_last = 1'b0;
        payload_ident = '0;
        s_done_tvalid = 1'b0;
        s_done_tdata = '0;
        m_cmd_tready = 1'b0;
        s_stat_tvalid = 1'b0;
        s_stat_tdata = '0;
        m_cmpl_tready = 1'b0;
        cmd_check_en = 1'b1;
        cmpl_check_en = 1'b1;
        hold_cmd_ready = 1'b0;
        checks = 0;
        errors = 0;
        tests = 0;
        cycles = 0;
        err_mark = 0;
        void'($urandom(32'h796a8b9f));
        wait (memresetn);
        @(negedge memclk);

        // no space without a done address
        repeat (4) begin
            compare("space", 72'd0, {71'd0, payload_has_space});
            @(negedge memclk);
        end
        s_done_tvalid = 1'b1;
        s_done_tdata = 16'h0123;
        @(negedge memclk);
        compare("space", 72'd1, {71'd0, payload_has_space});
        s_done_tvalid = 1'b0;
        @(negedge memclk);
        finish_test("space");

        // three events, commands against the model
        for (int e = 0; e < 3; e++) begin
            s_done_tdata = 16'($urandom);
            done_q.push_back(s_done_tdata[12:0]);
            run_event(s_done_tdata);
        end
        while (exp_cmd.size() != 0) @(negedge memclk);
        finish_test("cmds");

        // statuses reduced into completions
        for (int e = 0; e < 3; e++) begin
            run_status(done_q.pop_front());
        end
        while (exp_cmpl.size() != 0) @(negedge memclk);
        finish_test("cmpl");

        // a full event with no command ready overflows the FIFO
        cmd_check_en = 1'b0;
        hold_cmd_ready = 1'b1;
        addr = 13'($urandom);
        run_event({3'b000, addr});
        repeat (2) @(negedge memclk);
        compare("ovf", 72'd1, {71'd0, cmd_err.cmd_ovf});
        hold_cmd_ready = 1'b0;
        repeat (2) @(negedge memclk);
        while (m_cmd_tvalid) @(negedge memclk);
        compare("ovf", 72'd1, {71'd0, cmd_err.cmd_ovf});
        finish_test("ovf");

        // second last status has no event behind it
        cmpl_check_en = 1'b0;
        one_status(1'b1);
        compare("unf", 72'd0, {71'd0, cmd_err.done_unf});
        one_status(1'b1);
        repeat (2) @(negedge memclk);
        compare("unf", 72'd1, {71'd0, cmd_err.done_unf});
        // only the command overflow and the underflow were provoked
        compare("unf", 72'h9, {68'd0, cmd_err});
        while (m_cmpl_tvalid) @(negedge memclk);
        finish_test("unf");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end
endmodule

// File: sim/req_gen_assert.sv
module req_gen_assert (
    input logic                 memclk,
    input logic                 memresetn,
    input logic                 m_cmd_tvalid_o,
    input logic                 m_cmd_tready_i,
    input req_gen_pkg::dm_cmd_t m_cmd_tdata_o,
    input logic                 m_cmpl_tvalid_o,
    input logic                 s_done_tvalid_i,
    input logic                 s_done_tready_o
);
    ////////////////////////////////////////
    // stream rules
    ////////////////////////////////////////

    // sync reset clears both output streams
    a_reset_valid: assert property (@(posedge memclk)
        !memresetn |=> !m_cmd_tvalid_o && !m_cmpl_tvalid_o)
        else $error("valid output high after reset");

    // command held until taken
    a_cmd_hold: assert property (@(posedge memclk) disable iff (!memresetn)
        m_cmd_tvalid_o && !m_cmd_tready_i |=> m_cmd_tvalid_o && $stable(m_cmd_tdata_o))
        else $error("command changed or dropped before ready");

    // done address taken only when offered
    a_done_take: assert property (@(posedge memclk) disable iff (!memresetn)
        $rose(s_done_tready_o) |-> s_done_tvalid_i)
        else $error("done ready rose without done valid");
endmodule

bind req_gen_top req_gen_assert u_assert (
    .memclk          (memclk),
    .memresetn       (memresetn),
    .m_cmd_tvalid_o  (m_cmd_tvalid_o),
    .m_cmd_tready_i  (m_cmd_tready_i),
    .m_cmd_tdata_o   (m_cmd_tdata_o),
    .m_cmpl_tvalid_o (m_cmpl_tvalid_o),
    .s_done_tvalid_i (s_done_tvalid_i),
    .s_done_tready_o (s_done_tready_o)
);

// File: sim/tb_clkgen.sv
module tb_clkgen #(
    parameter int HALF_PERIOD = 10,
    parameter int RESET_CYCLES = 8
) (
    output logic memclk_o,
    output logic memresetn_o
);
    // free running clock, reset released on a falling edge
    initial begin
        memclk_o = 1'b0;
        forever #HALF_PERIOD memclk_o = ~memclk_o;
    end

    initial begin
        memresetn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge memclk_o);
        @(negedge memclk_o);
        memresetn_o = 1'b1;
    end
endmodule

// File: rtl/req_gen_top.sv
module req_gen_top #(
    parameter logic [6:0] BASE_ADDRESS_4KB = 7'd4,
    parameter int CMD_DEPTH = 16,
    parameter int DONE_DEPTH = 4,
    parameter int CMPL_DEPTH = 4
) (
    input  logic                     memclk,
    input  logic                     memresetn,
    input  logic                     payload_valid_i,
    input  logic                     payload_last_i,
    input  req_gen_pkg::ident_t      payload_ident_i,
    output logic                     payload_has_space_o,
    input  logic                     s_done_tvalid_i,
    input  logic [15:0]              s_done_tdata_i,
    output logic                     s_done_tready_o,
    output req_gen_pkg::dm_cmd_t     m_cmd_tdata_o,
    output logic                     m_cmd_tvalid_o,
    input  logic                     m_cmd_tready_i,
    input  logic                     s_stat_tvalid_i,
    input  req_gen_pkg::dm_status_t  s_stat_tdata_i,
    output req_gen_pkg::cmpl_t       m_cmpl_tdata_o,
    output logic                     m_cmpl_tvalid_o,
    input  logic                     m_cmpl_tready_i,
    output req_gen_pkg::fifo_err_t   cmd_err_o
);
    import req_gen_pkg::*;

    // command path
    logic                   cmd_wr;
    cmd_word_t              cmd_word;
    cmd_word_t              cmd_head;
    logic                   cmd_ovf;
    // done address path
    logic                   done_take;
    logic [DONE_ADDR_W-1:0] done_head;
    logic                   done_rd;
    logic                   done_ovf;
    logic                   done_unf;
    // completion path
    logic                   cmpl_wr;
    cmpl_t                  cmpl_word;
    logic                   cmpl_ovf;

    req_cmd_ctrl #(.BASE_ADDRESS_4KB(BASE_ADDRESS_4KB)) u_ctrl (
        .memclk          (memclk),
        .memresetn       (memresetn),
        .payload_valid_i (payload_valid_i),
        .payload_last_i  (payload_last_i),
        .payload_ident_i (payload_ident_i),
        .done_valid_i    (s_done_tvalid_i),
        .done_addr_i     (s_done_tdata_i[DONE_ADDR_W-1:0]),
        .cmd_wr_o        (cmd_wr),
        .cmd_word_o      (cmd_word),
        .done_take_o     (done_take),
        .has_space_o     (payload_has_space_o)
    );

    // the source holds its address until the final command takes it
    assign s_done_tready_o = done_take;

    ////////////////////////////////////////
    // command FIFO and DataMover expansion
    ////////////////////////////////////////

    req_sync_fifo #(.WIDTH($bits(cmd_word_t)), .DEPTH(CMD_DEPTH)) u_cmd_fifo (
        .memclk      (memclk),
        .memresetn   (memresetn),
        .wr_i        (cmd_wr),
        .din_i       (cmd_word),
        .rd_i        (m_cmd_tvalid_o && m_cmd_tready_i),
        .dout_o      (cmd_head),
        .valid_o     (m_cmd_tvalid_o),
        .overflow_o  (cmd_ovf),
        .underflow_o ()
    );

    // only the address and the tag change between commands
    always_comb begin
        m_cmd_tdata_o      = '0;
        // tag flags the last write of the event
        m_cmd_tdata_o.tag  = {3'b000, cmd_head.last_cmd};
        m_cmd_tdata_o.addr = {cmd_head.done_addr, cmd_head.kb_addr, 10'h000};
        m_cmd_tdata_o.drr  = 1'b0;
        m_cmd_tdata_o.eof  = 1'b1;
        m_cmd_tdata_o.dsa  = 6'h00;
        // incrementing burst
        m_cmd_tdata_o.typ  = 1'b1;
        m_cmd_tdata_o.btt  = CHUNK_BTT;
    end

    ////////////////////////////////////////
    // done addresses and completions
    ////////////////////////////////////////

    req_sync_fifo #(.WIDTH(DONE_ADDR_W), .DEPTH(DONE_DEPTH)) u_done_fifo (
        .memclk      (memclk),
        .memresetn   (memresetn),
        .wr_i        (done_take),
        .din_i       (s_done_tdata_i[DONE_ADDR_W-1:0]),
        .rd_i        (done_rd),
        .dout_o      (done_head),
        .valid_o     (),
        .overflow_o  (done_ovf),
        .underflow_o (done_unf)
    );

    dm_status_track u_stat (
        .memclk       (memclk),
        .memresetn    (memresetn),
        .stat_valid_i (s_stat_tvalid_i),
        .stat_i       (s_stat_tdata_i),
        .done_addr_i  (done_head),
        .cmpl_wr_o    (cmpl_wr),
        .cmpl_o       (cmpl_word),
        .done_rd_o    (done_rd),
        .ovf_i        ({cmpl_ovf, done_ovf, cmd_ovf}),
        .unf_i        (done_unf),
        .err_o        (cmd_err_o)
    );

    req_sync_fifo #(.WIDTH($bits(cmpl_t)), .DEPTH(CMPL_DEPTH)) u_cmpl_fifo (
        .memclk      (memclk),
        .memresetn   (memresetn),
        .wr_i        (cmpl_wr),
        .din_i       (cmpl_word),
        .rd_i        (m_cmpl_tvalid_o && m_cmpl_tready_i),
        .dout_o      (m_cmpl_tdata_o),
        .valid_o     (m_cmpl_tvalid_o),
        .overflow_o  (cmpl_ovf),
        .underflow_o ()
    );

endmodule

// File: rtl/dm_status_track.sv
module dm_status_track (
    input  logic                                memclk,
    input  logic                                memresetn,
    input  logic                                stat_valid_i,
    input  req_gen_pkg::dm_status_t             stat_i,
    input  logic [req_gen_pkg::DONE_ADDR_W-1:0] done_addr_i,
    output logic                                cmpl_wr_o,
    output req_gen_pkg::cmpl_t                  cmpl_o,
    output logic                                done_rd_o,
    input  logic [2:0]                          ovf_i,
    input  logic                                unf_i,
    output req_gen_pkg::fifo_err_t              err_o
);
    import req_gen_pkg::*;

    logic [3:0]  cur_err;
    logic        err_any;
    logic [3:0]  err_sticky;
    logic [26:0] err_shreg;
    logic        last_stat;

    ////////////////////////////////////////
    // status reduction
    ////////////////////////////////////////

    // not-okay on top of the three error bits
    assign cur_err   = {~stat_i.okay, stat_i.err};
    assign err_any   = |cur_err;
    assign last_stat = stat_valid_i && stat_i.last;

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            err_sticky <= '0;
            err_shreg  <= '0;
        end else if (stat_valid_i) begin
            // stickies restart with each event
            if (stat_i.last) err_sticky <= '0;
            else err_sticky <= err_sticky | cur_err;
            // one bit per transfer, 28th comes from the live status
            err_shreg <= {err_any, err_shreg[26:1]};
        end
    end

    // last status pops the done address and writes the completion
    assign done_rd_o = last_stat;
    assign cmpl_wr_o = last_stat;
    assign cmpl_o.pad = '0;
    assign cmpl_o.done_addr = done_addr_i;
    assign cmpl_o.err_word = {err_any, err_shreg, err_sticky | cur_err};

    ////////////////////////////////////////
    // FIFO error stickies
    ////////////////////////////////////////

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            err_o <= '0;
        end else begin
            if (ovf_i[0]) err_o.cmd_ovf <= 1'b1;
            if (ovf_i[1]) err_o.done_ovf <= 1'b1;
            if (ovf_i[2]) err_o.cmpl_ovf <= 1'b1;
            // status with no event pending, logic fault upstream
            if (unf_i) err_o.done_unf <= 1'b1;
        end
    end

endmodule

// File: rtl/req_cmd_ctrl.sv
module req_cmd_ctrl #(
    parameter logic [6:0] BASE_ADDRESS_4KB = 7'd4
) (
    input  logic                                memclk,
    input  logic                                memresetn,
    input  logic                                payload_valid_i,
    input  logic                                payload_last_i,
    input  req_gen_pkg::ident_t                 payload_ident_i,
    input  logic                                done_valid_i,
    input  logic [req_gen_pkg::DONE_ADDR_W-1:0] done_addr_i,
    output logic                                cmd_wr_o,
    output req_gen_pkg::cmd_word_t              cmd_word_o,
    output logic                                done_take_o,
    output logic                                has_space_o
);
    import req_gen_pkg::*;

    // base of this TURFIO's share in KB
    localparam logic [KB_ADDR_W-1:0] BASE_ADDRESS_KB = {BASE_ADDRESS_4KB, 2'b00};

    localparam logic [2:0] IDLE      = 3'd0;
    localparam logic [2:0] LOAD_BASE = 3'd1;
    localparam logic [2:0] WAIT_LAST = 3'd2;
    localparam logic [2:0] INCR      = 3'd3;
    localparam logic [2:0] WAIT_NEXT = 3'd4;

    logic [2:0]           state;
    logic [KB_ADDR_W-1:0] kb_addr;
    logic [KB_ADDR_W-1:0] chunk_base;
    logic [KB_ADDR_W-1:0] addend_a;
    logic [KB_ADDR_W-1:0] addend_b;
    logic                 last_marker;
    logic                 final_cmd;

    ////////////////////////////////////////
    // address adder
    ////////////////////////////////////////

    // start of this chunk inside SURF 0
    assign chunk_base = BASE_ADDRESS_KB + KB_ADDR_W'(payload_ident_i.chunk) * CHUNK_SIZE_KB;

    // one adder serves both the base load and the SURF step
    assign addend_a = (state == LOAD_BASE) ? chunk_base : kb_addr;
    assign addend_b = (state == INCR) ? SURF_SIZE_KB : '0;

    always_ff @(posedge memclk) begin
        if (state == LOAD_BASE || state == INCR) begin
            kb_addr <= addend_a + addend_b;
        end
    end

    ////////////////////////////////////////
    // command and done-address writes
    ////////////////////////////////////////

    assign last_marker = (state == WAIT_LAST) && payload_valid_i && payload_last_i;
    // chunk 3 of SURF 6 closes the event
    assign final_cmd = (payload_ident_i.chunk == LAST_CHUNK) &&
                       (payload_ident_i.surf == LAST_SURF);

    assign cmd_wr_o = last_marker;
    assign cmd_word_o.last_cmd = final_cmd;
    assign cmd_word_o.done_addr = done_addr_i;
    assign cmd_word_o.kb_addr = kb_addr;

    // the done address is released with the final command only
    assign done_take_o = last_marker && final_cmd;

    // an address on hand, or one already held for the event in progress
    assign has_space_o = (state == WAIT_NEXT) || (state == IDLE && done_valid_i);

    ////////////////////////////////////////
    // chunk marker FSM
    ////////////////////////////////////////

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            state <= IDLE;
        end else begin
            case (state)
                // need both a marker and an address to start an event
                IDLE: begin
                    if (payload_valid_i && done_valid_i) begin
                        state <= LOAD_BASE;
                    end
                end
                LOAD_BASE: state <= WAIT_LAST;
                WAIT_LAST: begin
                    if (payload_valid_i && payload_last_i) begin
                        if (payload_ident_i.surf != LAST_SURF) begin
                            state <= INCR;
                        end else if (final_cmd) begin
                            state <= IDLE;
                        end else begin
                            state <= WAIT_NEXT;
                        end
                    end
                end
                INCR: state <= WAIT_LAST;
                // next chunk starts back at SURF 0
                WAIT_NEXT: begin
                    if (payload_valid_i) begin
                        state <= LOAD_BASE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: rtl/req_sync_fifo.sv
module req_sync_fifo #(
    parameter int WIDTH = 8,
    // power of two, at least 2
    parameter int DEPTH = 4
) (
    input  logic             memclk,
    input  logic             memresetn,
    input  logic             wr_i,
    input  logic [WIDTH-1:0] din_i,
    input  logic             rd_i,
    output logic [WIDTH-1:0] dout_o,
    output logic             valid_o,
    output logic             overflow_o,
    output logic             underflow_o
);
    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    mem_cnt;
    logic             full;
    logic             rd_ok;
    logic             wr_ok;
    logic             out_load;
    logic             mem_pop;
    logic             mem_push;

    // head word lives in the output register, the rest in mem
    assign full     = valid_o && (mem_cnt == CW'(DEPTH));
    assign rd_ok    = rd_i && valid_o;
    assign wr_ok    = wr_i && !full;
    assign out_load = !valid_o || rd_ok;
    assign mem_pop  = out_load && (mem_cnt != '0);
    // bypass straight to the output when mem is empty
    assign mem_push = wr_ok && !(out_load && mem_cnt == '0);

    always_ff @(posedge memclk) begin
        if (mem_push) begin
            mem[wr_ptr] <= din_i;
        end
        if (mem_pop) begin
            dout_o <= mem[rd_ptr];
        end else if (out_load && wr_ok) begin
            dout_o <= din_i;
        end
    end

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            mem_cnt     <= '0;
            valid_o     <= 1'b0;
            overflow_o  <= 1'b0;
            underflow_o <= 1'b0;
        end else begin
            if (mem_push) wr_ptr <= wr_ptr + 1'b1;
            if (mem_pop) rd_ptr <= rd_ptr + 1'b1;
            mem_cnt <= mem_cnt + CW'(mem_push) - CW'(mem_pop);
            if (out_load) valid_o <= mem_pop || wr_ok;
            // dropped write / read of nothing, one cycle each
            overflow_o  <= wr_i && full;
            underflow_o <= rd_i && !valid_o;
        end
    end

endmodule

// File: rtl/req_gen_pkg.sv
package req_gen_pkg;

    ////////////////////////////////////////
    // address map constants
    ////////////////////////////////////////

    // chunk length in 1 KB units
    localparam logic [8:0] CHUNK_SIZE_KB = 9'd4;
    // four chunks per SURF, so SURFs sit 16 KB apart
    localparam logic [8:0] SURF_SIZE_KB = 9'd16;
    localparam int SURFS_PER_TIO = 7;
    localparam logic [2:0] LAST_SURF = 3'(SURFS_PER_TIO - 1);
    localparam logic [1:0] LAST_CHUNK = 2'd3;
    // bytes per DataMover transfer, always one full chunk
    localparam logic [22:0] CHUNK_BTT = {4'h0, CHUNK_SIZE_KB, 10'h000};

    // done address is 13 bits, kb address within the event is 9
    localparam int DONE_ADDR_W = 13;
    localparam int KB_ADDR_W = 9;

    ////////////////////////////////////////
    // stream and queue words
    ////////////////////////////////////////

    // marker ident: chunk in the upper bits, SURF below
    typedef struct packed {
        logic [1:0] chunk;
        logic [2:0] surf;
    } ident_t;

    // compact command as queued, low 10 address bits are always zero
    typedef struct packed {
        logic                   last_cmd;
        logic [DONE_ADDR_W-1:0] done_addr;
        logic [KB_ADDR_W-1:0]   kb_addr;
    } cmd_word_t;

    // 72-bit DataMover S2MM command
    typedef struct packed {
        logic [3:0]  rsvd;
        logic [3:0]  tag;
        logic [31:0] addr;
        logic        drr;
        logic        eof;
        logic [5:0]  dsa;
        logic        typ;
        logic [22:0] btt;
    } dm_cmd_t;

    // DataMover status byte
    typedef struct packed {
        logic       okay;
        logic [2:0] err;
        logic [2:0] rsvd;
        logic       last;
    } dm_status_t;

    // completion: done address over the reduced error word
    typedef struct packed {
        logic [18:0]            pad;
        logic [DONE_ADDR_W-1:0] done_addr;
        logic [31:0]            err_word;
    } cmpl_t;

    // sticky FIFO errors, cmd_ovf is bit 0
    typedef struct packed {
        logic done_unf;
        logic cmpl_ovf;
        logic done_ovf;
        logic cmd_ovf;
    } fifo_err_t;

endpackage
